//--- hdl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    localparam logic [6:0] op_rtype = 7'b0110011;
    localparam logic [6:0] op_itype = 7'b0010011;
    localparam logic [6:0] op_load = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal = 7'b1101111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt
    } alu_op_e;

    typedef enum logic [1:0] {
        res_alu,
        res_load,
        res_pc4
    } result_src_e;

    typedef enum logic [1:0] {
        fwd_rf,
        fwd_mem,
        fwd_wb
    } fwd_sel_e;

    // an all-zero payload is a bubble
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pc_plus4;
        logic [xlen-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic reg_write;
        result_src_e result_src;
        logic mem_write;
        logic mem_read;
        logic jump;
        logic branch;
        alu_op_e alu_op;
        logic alu_src;
        logic [xlen-1:0] rd1;
        logic [xlen-1:0] rd2;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pc_plus4;
    } id_ex_t;

    typedef struct packed {
        logic reg_write;
        result_src_e result_src;
        logic mem_write;
        logic mem_read;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] write_data;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0] pc_plus4;
    } ex_mem_t;

    typedef struct packed {
        logic reg_write;
        result_src_e result_src;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] read_data;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0] pc_plus4;
    } mem_wb_t;

    typedef struct packed {
        logic reg_write;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0] result;
    } wb_t;

endpackage

`default_nettype wire

//--- hdl/pipe_reg.sv
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic flush,
    input payload_t d,
    output payload_t q
);

    // flush wins over stall, all-zero payload is the bubble
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
`default_nettype none

module fetch_stage (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic pc_src,
    input logic [rv_pkg::xlen-1:0] pc_target,
    input logic [rv_pkg::xlen-1:0] instr,
    output logic [rv_pkg::xlen-1:0] pc,
    output rv_pkg::if_id_t if_id
);
    import rv_pkg::*;

    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_next;

    assign pc_plus4 = pc + 32'd4;
    assign pc_next = pc_src ? pc_target : pc_plus4;

    // stall wins, a held branch fires again once the pipe moves
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc_next;
        end
    end

    assign if_id.pc = pc;
    assign if_id.pc_plus4 = pc_plus4;
    assign if_id.instr = instr;

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`default_nettype none

module decode_stage (
    input logic clk,
    input logic rst,
    input rv_pkg::if_id_t if_id,
    input rv_pkg::wb_t wb,
    output rv_pkg::id_ex_t id_ex
);
    import rv_pkg::*;

    logic [xlen-1:0] regs [2**reg_addr_w];
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_j;
    logic valid;

    assign opcode = if_id.instr[6:0];
    assign funct3 = if_id.instr[14:12];
    assign rs1 = if_id.instr[19:15];
    assign rs2 = if_id.instr[24:20];

    assign imm_i = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
    assign imm_s = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
    assign imm_b = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
                    if_id.instr[30:25], if_id.instr[11:8], 1'b0};
    assign imm_j = {{11{if_id.instr[31]}}, if_id.instr[31], if_id.instr[19:12],
                    if_id.instr[20], if_id.instr[30:21], 1'b0};

    // no writes while in reset
    always_ff @(posedge clk) begin
        if (!rst && wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // x0 reads zero, same-cycle write bypassed
    always_comb begin
        if (rs1 == '0) begin
            rd1 = '0;
        end else if (wb.reg_write && wb.rd == rs1) begin
            rd1 = wb.result;
        end else begin
            rd1 = regs[rs1];
        end
        if (rs2 == '0) begin
            rd2 = '0;
        end else if (wb.reg_write && wb.rd == rs2) begin
            rd2 = wb.result;
        end else begin
            rd2 = regs[rs2];
        end
    end

    always_comb begin
        id_ex = '0;
        valid = 1'b1;
        case (opcode)
            op_rtype: begin
                id_ex.reg_write = 1'b1;
                case (funct3)
                    3'b000: id_ex.alu_op = if_id.instr[30] ? alu_sub : alu_add;
                    3'b111: id_ex.alu_op = alu_and;
                    3'b110: id_ex.alu_op = alu_or;
                    3'b100: id_ex.alu_op = alu_xor;
                    3'b010: id_ex.alu_op = alu_slt;
                    default: valid = 1'b0;
                endcase
            end
            op_itype: begin
                id_ex.reg_write = 1'b1;
                id_ex.alu_src = 1'b1;
                id_ex.imm = imm_i;
                // addi only
                valid = (funct3 == 3'b000);
            end
            op_load: begin
                id_ex.reg_write = 1'b1;
                id_ex.result_src = res_load;
                id_ex.mem_read = 1'b1;
                id_ex.alu_src = 1'b1;
                id_ex.imm = imm_i;
            end
            op_store: begin
                id_ex.mem_write = 1'b1;
                id_ex.alu_src = 1'b1;
                id_ex.imm = imm_s;
            end
            op_branch: begin
                id_ex.branch = 1'b1;
                id_ex.imm = imm_b;
            end
            op_jal: begin
                id_ex.reg_write = 1'b1;
                id_ex.result_src = res_pc4;
                id_ex.jump = 1'b1;
                id_ex.imm = imm_j;
            end
            default: valid = 1'b0;
        endcase
        if (valid) begin
            id_ex.rd1 = rd1;
            id_ex.rd2 = rd2;
            id_ex.rs1 = rs1;
            id_ex.rs2 = rs2;
            id_ex.rd = if_id.instr[11:7];
            id_ex.pc = if_id.pc;
            id_ex.pc_plus4 = if_id.pc_plus4;
        end else begin
            id_ex = '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/exec_stage.sv
`default_nettype none

module exec_stage (
    input rv_pkg::id_ex_t id_ex,
    input rv_pkg::fwd_sel_e fwd_a,
    input rv_pkg::fwd_sel_e fwd_b,
    input logic [rv_pkg::xlen-1:0] mem_result,
    input logic [rv_pkg::xlen-1:0] wb_result,
    output rv_pkg::ex_mem_t ex_mem,
    output logic pc_src,
    output logic [rv_pkg::xlen-1:0] pc_target
);
    import rv_pkg::*;

    logic [xlen-1:0] src_a;
    logic [xlen-1:0] src_b_reg;
    logic [xlen-1:0] src_b;
    logic [xlen-1:0] alu_result;

    function automatic logic [xlen-1:0] fwd_mux(
        input fwd_sel_e sel,
        input logic [xlen-1:0] rf_val,
        input logic [xlen-1:0] mem_val,
        input logic [xlen-1:0] wb_val
    );
        case (sel)
            fwd_mem: return mem_val;
            fwd_wb: return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign src_a = fwd_mux(fwd_a, id_ex.rd1, mem_result, wb_result);
    assign src_b_reg = fwd_mux(fwd_b, id_ex.rd2, mem_result, wb_result);
    assign src_b = id_ex.alu_src ? id_ex.imm : src_b_reg;

    always_comb begin
        case (id_ex.alu_op)
            alu_sub: alu_result = src_a - src_b;
            alu_and: alu_result = src_a & src_b;
            alu_or: alu_result = src_a | src_b;
            alu_xor: alu_result = src_a ^ src_b;
            alu_slt: alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
            default: alu_result = src_a + src_b;
        endcase
    end

    // beq compares the forwarded registers, not the alu input
    assign pc_src = id_ex.jump || (id_ex.branch && src_a == src_b_reg);
    assign pc_target = id_ex.pc + id_ex.imm;

    assign ex_mem.reg_write = id_ex.reg_write;
    assign ex_mem.result_src = id_ex.result_src;
    assign ex_mem.mem_write = id_ex.mem_write;
    assign ex_mem.mem_read = id_ex.mem_read;
    assign ex_mem.alu_result = alu_result;
    assign ex_mem.write_data = src_b_reg;
    assign ex_mem.rd = id_ex.rd;
    assign ex_mem.pc_plus4 = id_ex.pc_plus4;

endmodule

`default_nettype wire

//--- hdl/hazard_unit.sv
`default_nettype none

module hazard_unit (
    input rv_pkg::id_ex_t id_ex_d,
    input rv_pkg::id_ex_t id_ex_q,
    input rv_pkg::ex_mem_t ex_mem,
    input rv_pkg::wb_t wb,
    input logic pc_src,
    input logic read_valid,
    output logic stall_f,
    output logic stall_d,
    output logic stall_e,
    output logic stall_m,
    output logic stall_w,
    output logic flush_d,
    output logic flush_e,
    output rv_pkg::fwd_sel_e fwd_a,
    output rv_pkg::fwd_sel_e fwd_b
);
    import rv_pkg::*;

    logic load_use;
    logic mem_wait;

    assign load_use = id_ex_q.mem_read && id_ex_q.rd != '0 &&
                      (id_ex_q.rd == id_ex_d.rs1 || id_ex_q.rd == id_ex_d.rs2);

    // load in memory stage still waiting for its data
    assign mem_wait = ex_mem.mem_read && !read_valid;

    assign stall_f = load_use || mem_wait;
    assign stall_d = load_use || mem_wait;
    assign stall_e = mem_wait;
    assign stall_m = mem_wait;
    assign stall_w = mem_wait;

    // a frozen pipe must not drop the branch or the load
    assign flush_d = pc_src && !mem_wait;
    assign flush_e = (pc_src || load_use) && !mem_wait;

    always_comb begin
        fwd_a = fwd_rf;
        fwd_b = fwd_rf;
        if (ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == id_ex_q.rs1) begin
            fwd_a = fwd_mem;
        end else if (wb.reg_write && wb.rd != '0 && wb.rd == id_ex_q.rs1) begin
            fwd_a = fwd_wb;
        end
        if (ex_mem.reg_write && ex_mem.rd != '0 && ex_mem.rd == id_ex_q.rs2) begin
            fwd_b = fwd_mem;
        end else if (wb.reg_write && wb.rd != '0 && wb.rd == id_ex_q.rs2) begin
            fwd_b = fwd_wb;
        end
    end

endmodule

`default_nettype wire

//--- hdl/riscv_pipeline.sv
`default_nettype none

module riscv_pipeline (
    input logic clk,
    input logic rst,
    input logic [rv_pkg::xlen-1:0] instr,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic instr_en,
    input logic [rv_pkg::xlen-1:0] read_data,
    input logic read_valid,
    output logic data_we,
    output logic data_re,
    output logic [rv_pkg::xlen-1:0] data_addr,
    output logic [rv_pkg::xlen-1:0] wdata
);
    import rv_pkg::*;

    if_id_t if_id_d;
    if_id_t if_id_q;
    id_ex_t id_ex_d;
    id_ex_t id_ex_q;
    ex_mem_t ex_mem_d;
    ex_mem_t ex_mem_q;
    mem_wb_t mem_wb_d;
    mem_wb_t mem_wb_q;
    wb_t wb;

    logic [xlen-1:0] mem_result;
    logic [xlen-1:0] pc_target;
    logic pc_src;
    logic stall_f;
    logic stall_d;
    logic stall_e;
    logic stall_m;
    logic stall_w;
    logic flush_d;
    logic flush_e;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    fetch_stage i_fetch (
        .clk(clk),
        .rst(rst),
        .stall(stall_f),
        .pc_src(pc_src),
        .pc_target(pc_target),
        .instr(instr),
        .pc(pc),
        .if_id(if_id_d)
    );

    assign instr_en = !stall_f;

    pipe_reg #(.payload_t(if_id_t)) i_if_id_reg (
        .clk(clk),
        .rst(rst),
        .stall(stall_d),
        .flush(flush_d),
        .d(if_id_d),
        .q(if_id_q)
    );

    decode_stage i_decode (
        .clk(clk),
        .rst(rst),
        .if_id(if_id_q),
        .wb(wb),
        .id_ex(id_ex_d)
    );

    pipe_reg #(.payload_t(id_ex_t)) i_id_ex_reg (
        .clk(clk),
        .rst(rst),
        .stall(stall_e),
        .flush(flush_e),
        .d(id_ex_d),
        .q(id_ex_q)
    );

    exec_stage i_exec (
        .id_ex(id_ex_q),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b),
        .mem_result(mem_result),
        .wb_result(wb.result),
        .ex_mem(ex_mem_d),
        .pc_src(pc_src),
        .pc_target(pc_target)
    );

    pipe_reg #(.payload_t(ex_mem_t)) i_ex_mem_reg (
        .clk(clk),
        .rst(rst),
        .stall(stall_m),
        .flush(1'b0),
        .d(ex_mem_d),
        .q(ex_mem_q)
    );

    // taken from the memory-stage register, so it holds through a load wait
    assign data_we = ex_mem_q.mem_write;
    assign data_re = ex_mem_q.mem_read;
    assign data_addr = ex_mem_q.alu_result;
    assign wdata = ex_mem_q.write_data;

    // jal link value must forward too
    assign mem_result = (ex_mem_q.result_src == res_pc4) ? ex_mem_q.pc_plus4
                                                        : ex_mem_q.alu_result;

    assign mem_wb_d.reg_write = ex_mem_q.reg_write;
    assign mem_wb_d.result_src = ex_mem_q.result_src;
    assign mem_wb_d.alu_result = ex_mem_q.alu_result;
    assign mem_wb_d.read_data = read_data;
    assign mem_wb_d.rd = ex_mem_q.rd;
    assign mem_wb_d.pc_plus4 = ex_mem_q.pc_plus4;

    pipe_reg #(.payload_t(mem_wb_t)) i_mem_wb_reg (
        .clk(clk),
        .rst(rst),
        .stall(stall_w),
        .flush(1'b0),
        .d(mem_wb_d),
        .q(mem_wb_q)
    );

    always_comb begin
        wb.reg_write = mem_wb_q.reg_write;
        wb.rd = mem_wb_q.rd;
        case (mem_wb_q.result_src)
            res_load: wb.result = mem_wb_q.read_data;
            res_pc4: wb.result = mem_wb_q.pc_plus4;
            default: wb.result = mem_wb_q.alu_result;
        endcase
    end

    hazard_unit i_hazard (
        .id_ex_d(id_ex_d),
        .id_ex_q(id_ex_q),
        .ex_mem(ex_mem_q),
        .wb(wb),
        .pc_src(pc_src),
        .read_valid(read_valid),
        .stall_f(stall_f),
        .stall_d(stall_d),
        .stall_e(stall_e),
        .stall_m(stall_m),
        .stall_w(stall_w),
        .flush_d(flush_d),
        .flush_e(flush_e),
        .fwd_a(fwd_a),
        .fwd_b(fwd_b)
    );

endmodule

`default_nettype wire

//--- tests/riscv_pipeline_assert.sv
`default_nettype none

module riscv_pipeline_assert (
    input logic clk,
    input logic rst,
    input logic data_we,
    input logic data_re,
    input logic read_valid,
    input logic [31:0] data_addr,
    input logic instr_en,
    input logic [31:0] pc
);
    timeunit 1ns;
    timeprecision 1ps;

    // one edge into reset the memory payload is a bubble
    no_store_in_reset: assert property (@(posedge clk) rst |=> !data_we)
        else $error("data_we high while rst is high");

    load_addr_stable: assert property (@(posedge clk) disable iff (rst)
        (data_re && !read_valid) |=> $stable(data_addr))
        else $error("data_addr changed while a load waited for read_valid");

    // a disabled fetch keeps the pc
    fetch_hold_when_disabled: assert property (@(posedge clk) disable iff (rst)
        !instr_en |=> $stable(pc))
        else $error("pc moved while instr_en was low");

endmodule

bind riscv_pipeline riscv_pipeline_assert riscv_pipeline_assert_i (
    .clk(clk),
    .rst(rst),
    .data_we(data_we),
    .data_re(data_re),
    .read_valid(read_valid),
    .data_addr(data_addr),
    .instr_en(instr_en),
    .pc(pc)
);

`default_nettype wire

//--- tests/tb_riscv_pipeline.sv
`default_nettype none

module tb_riscv_pipeline;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] seed = 32'h330a_4df8;
    localparam logic [31:0] done_addr = 32'h0000_00fc;
    // alu 20, four load-use runs of 9, two branch runs of 7, jal 6
    localparam int total_instr = 76;
    localparam int watchdog_cycles = total_instr * 20;

    logic clk;
    logic rst;
    logic [31:0] instr;
    logic [31:0] pc;
    logic instr_en;
    logic [31:0] read_data;
    logic read_valid;
    logic data_we;
    logic data_re;
    logic [31:0] data_addr;
    logic [31:0] wdata;

    logic [31:0] imem [64];
    logic [31:0] dmem [64];
    logic [31:0] rng_state;
    int prog_len;
    int lat_left;
    logic load_busy;
    logic done_seen;

    riscv_pipeline riscv_pipeline_i (
        .clk(clk),
        .rst(rst),
        .instr(instr),
        .pc(pc),
        .instr_en(instr_en),
        .read_data(read_data),
        .read_valid(read_valid),
        .data_we(data_we),
        .data_re(data_re),
        .data_addr(data_addr),
        .wdata(wdata)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] fill_word(input logic [5:0] idx);
        return 32'ha5a5_0000 ^ {24'd0, idx, 2'b00};
    endfunction

    function automatic logic [31:0] sext12(input logic [31:0] r);
        return {{20{r[11]}}, r[11:0]};
    endfunction

    function automatic logic [31:0] alu_word(
        input logic [6:0] funct7,
        input logic [2:0] funct3,
        input logic [4:0] rd,
        input logic [4:0] rs1,
        input logic [4:0] rs2
    );
        return {funct7, rs2, rs1, funct3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(
        input logic [4:0] rd,
        input logic [4:0] rs1,
        input logic [31:0] imm
    );
        return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw_word(
        input logic [4:0] rd,
        input logic [4:0] rs1,
        input logic [31:0] imm
    );
        return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_word(
        input logic [4:0] rs2,
        input logic [4:0] rs1,
        input logic [31:0] imm
    );
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq_word(
        input logic [4:0] rs1,
        input logic [4:0] rs2,
        input logic [31:0] imm
    );
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic draw_random(output logic [31:0] value);
        rng_state = xorshift(rng_state);
        value = rng_state;
    endtask

    task automatic emit(input logic [31:0] word);
        imem[prog_len[5:0]] = word;
        prog_len++;
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, want);
            $display("Test failures found");
            $fatal(1, "value mismatch");
        end
    endtask

    // both memory models, inputs change only on the falling edge
    task automatic clock_cycle();
        @(negedge clk);
        if (rst) begin
            read_valid = 1'b0;
            load_busy = 1'b0;
        end else begin
            if (read_valid) begin
                // load was taken at the last rising edge
                read_valid = 1'b0;
                load_busy = 1'b0;
            end
            if (data_we) begin
                dmem[data_addr[7:2]] = wdata;
                if (data_addr == done_addr) begin
                    done_seen = 1'b1;
                end
            end
            if (data_re && !load_busy) begin
                load_busy = 1'b1;
                draw_random(rng_state);
                lat_left = int'(rng_state[1:0]);
            end
            if (load_busy) begin
                if (lat_left == 0) begin
                    read_valid = 1'b1;
                    read_data = dmem[data_addr[7:2]];
                end else begin
                    lat_left--;
                end
            end
        end
        instr = imem[pc[7:2]];
    endtask

    task automatic begin_test();
        clock_cycle();
        rst = 1'b1;
        prog_len = 0;
        done_seen = 1'b0;
        for (int i = 0; i < 64; i++) begin
            imem[i[5:0]] = '0;
            dmem[i[5:0]] = fill_word(i[5:0]);
        end
    endtask

    // reset checks, then run until the done store
    task automatic run_program();
        repeat (5) begin
            clock_cycle();
            check_equal("pc during reset", pc, 32'h0);
            check_equal("data_we during reset", {31'b0, data_we}, 32'h0);
        end
        rst = 1'b0;
        check_equal("instr_en after reset", {31'b0, instr_en}, 32'h1);
        clock_cycle();
        check_equal("pc after first fetch", pc, 32'h4);
        while (!done_seen) begin
            clock_cycle();
        end
    endtask

    task automatic alu_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] want [8];
        begin_test();
        draw_random(a);
        draw_random(b);
        draw_random(c);
        a = sext12(a);
        b = sext12(b);
        c = sext12(c);
        emit(addi_word(5'd1, 5'd0, a));
        emit(addi_word(5'd2, 5'd0, b));
        emit(alu_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(alu_word(7'h20, 3'b000, 5'd4, 5'd3, 5'd1));
        emit(alu_word(7'h00, 3'b111, 5'd5, 5'd4, 5'd2));
        emit(alu_word(7'h00, 3'b110, 5'd6, 5'd5, 5'd3));
        emit(alu_word(7'h00, 3'b100, 5'd7, 5'd6, 5'd4));
        emit(alu_word(7'h00, 3'b010, 5'd8, 5'd1, 5'd7));
        // write to x0 must vanish
        emit(addi_word(5'd0, 5'd1, c));
        emit(alu_word(7'h00, 3'b000, 5'd9, 5'd0, 5'd3));
        emit(addi_word(5'd10, 5'd8, c));
        for (int r = 3; r <= 10; r++) begin
            emit(sw_word(r[4:0], 5'd0, (r - 3) * 4));
        end
        emit(sw_word(5'd0, 5'd0, done_addr));
        want[0] = a + b;
        want[1] = want[0] - a;
        want[2] = want[1] & b;
        want[3] = want[2] | want[0];
        want[4] = want[3] ^ want[1];
        want[5] = {31'b0, $signed(a) < $signed(want[4])};
        want[6] = want[0];
        want[7] = want[5] + c;
        run_program();
        for (int i = 0; i < 8; i++) begin
            check_equal($sformatf("alu store %0d", i), dmem[i[5:0]], want[i[2:0]]);
        end
    endtask

    task automatic load_use_test();
        logic [31:0] a;
        logic [31:0] w1;
        logic [31:0] w2;
        begin_test();
        draw_random(a);
        draw_random(w1);
        draw_random(w2);
        a = sext12(a);
        dmem[8] = w1;
        dmem[10] = w2;
        emit(addi_word(5'd1, 5'd0, a));
        emit(lw_word(5'd2, 5'd0, 32'h20));
        emit(alu_word(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));
        emit(sw_word(5'd3, 5'd0, 32'h24));
        emit(lw_word(5'd4, 5'd0, 32'h20));
        emit(lw_word(5'd5, 5'd0, 32'h28));
        emit(alu_word(7'h00, 3'b000, 5'd6, 5'd5, 5'd4));
        emit(sw_word(5'd6, 5'd0, 32'h2c));
        emit(sw_word(5'd0, 5'd0, done_addr));
        run_program();
        check_equal("load-use sum", dmem[9], w1 + a);
        check_equal("back-to-back load sum", dmem[11], w1 + w2);
    endtask

    task automatic branch_test(input logic taken);
        logic [31:0] second;
        begin_test();
        second = taken ? 32'd7 : 32'd9;
        emit(addi_word(5'd1, 5'd0, 32'd7));
        emit(addi_word(5'd2, 5'd0, second));
        emit(beq_word(5'd1, 5'd2, 32'd12));
        emit(sw_word(5'd1, 5'd0, 32'h30));
        emit(sw_word(5'd1, 5'd0, 32'h34));
        emit(sw_word(5'd2, 5'd0, 32'h38));
        emit(sw_word(5'd0, 5'd0, done_addr));
        run_program();
        if (taken) begin
            check_equal("skipped marker 0", dmem[12], fill_word(6'd12));
            check_equal("skipped marker 1", dmem[13], fill_word(6'd13));
        end else begin
            check_equal("fall-through marker 0", dmem[12], 32'd7);
            check_equal("fall-through marker 1", dmem[13], 32'd7);
        end
        check_equal("store after branch", dmem[14], second);
    endtask

    task automatic jal_test();
        logic [31:0] jal_pc;
        begin_test();
        jal_pc = 32'd4;
        emit(addi_word(5'd1, 5'd0, 32'd3));
        emit(jal_word(5'd5, 32'd12));
        emit(sw_word(5'd1, 5'd0, 32'h40));
        emit(sw_word(5'd1, 5'd0, 32'h44));
        emit(sw_word(5'd5, 5'd0, 32'h48));
        emit(sw_word(5'd0, 5'd0, done_addr));
        run_program();
        check_equal("jal skipped marker 0", dmem[16], fill_word(6'd16));
        check_equal("jal skipped marker 1", dmem[17], fill_word(6'd17));
        check_equal("jal link value", dmem[18], jal_pc + 32'd4);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        instr = '0;
        read_data = '0;
        read_valid = 1'b0;
        rng_state = seed;
        load_busy = 1'b0;
        lat_left = 0;
        prog_len = 0;
        done_seen = 1'b0;
        alu_test();
        repeat (4) begin
            load_use_test();
        end
        branch_test(1'b1);
        branch_test(1'b0);
        jal_test();
        $display("All tests passed!");
        $finish;
    end

    initial begin
        #(watchdog_cycles * 4);
        $display("Test failures found");
        $fatal(1, "watchdog expired before the tests finished");
    end

endmodule

`default_nettype wire

//--- sources.f
hdl/rv_pkg.sv
hdl/pipe_reg.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/exec_stage.sv
hdl/hazard_unit.sv
hdl/riscv_pipeline.sv
tests/riscv_pipeline_assert.sv
tests/tb_riscv_pipeline.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_riscv_pipeline
FILELIST ?= sources.f
FLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ps
OBJ_DIR ?= obj_dir
SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
